/* Makefile */
# Verilator build and run for the masked Barrett correction testbench

TOP := tb_barrett_fix
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module $(TOP) -f filelist.f -Mdir obj_dir

# The log decides pass or fail, not the simulator exit status
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* b2a_conv.sv */
`timescale 1ns/1ns
// Masked Boolean-to-arithmetic share conversion, Goubin method
// Input x = x0 ^ x1, output a0 + a1 = x modulo 2^WIDTH
// Stage 1 registers the masked psi terms, stage 2 combines them

module b2a_conv #(
    parameter int WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  zeroize,
    input  masked_pkg::q_shares_t x_bool,
    input  logic [WIDTH-1:0]      rnd,
    output masked_pkg::q_shares_t x_arith
);

    // Masked value, Boolean mask and helper mask
    logic [WIDTH-1:0] x_masked;
    logic [WIDTH-1:0] x_mask;
    logic [WIDTH-1:0] gamma;

    // Stage 1 registers
    logic [WIDTH-1:0] psi_g_q;
    logic [WIDTH-1:0] psi_rg_q;
    logic [WIDTH-1:0] x_masked_q;
    logic [WIDTH-1:0] x_mask_q;

    // Stage 2 registers, arithmetic shares
    logic [WIDTH-1:0] a0_q;
    logic [WIDTH-1:0] a1_q;

    assign x_masked = x_bool[0];
    assign x_mask   = x_bool[1];
    assign gamma    = rnd;

    // ------------------------------------------------------------
    // Stage 1: psi(gamma) and psi(r ^ gamma)
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            psi_g_q    <= '0;
            psi_rg_q   <= '0;
            x_masked_q <= '0;
            x_mask_q   <= '0;
        end else begin
            // psi(a) = (x' ^ a) - a, affine over GF(2)
            psi_g_q    <= (x_masked ^ gamma) - gamma;
            psi_rg_q   <= (x_masked ^ x_mask ^ gamma) - (x_mask ^ gamma);
            x_masked_q <= x_masked;
            x_mask_q   <= x_mask;
        end
    end

    // ------------------------------------------------------------
    // Stage 2: psi(r) = psi(gamma) ^ psi(r ^ gamma) ^ psi(0)
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            a0_q <= '0;
            a1_q <= '0;
        end else begin
            a0_q <= psi_g_q ^ psi_rg_q ^ x_masked_q;
            // Boolean mask becomes the second arithmetic share
            a1_q <= x_mask_q;
        end
    end

    assign x_arith[0] = a0_q;
    assign x_arith[1] = a1_q;

endmodule

/* barrett_fix_top.sv */
`timescale 1ns/1ns
// Masked Barrett final correction, top level
// Decode, masked conditional q subtraction and credited result queue

module barrett_fix_top #(
    parameter int          QUEUE_DEPTH = 8,
    parameter int          OUT_CREDITS = 4,
    parameter logic [31:0] LFSR_SEED   = 32'h1b2c_3d4f
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         zeroize,
    // Request side
    input  logic                         in_valid,
    input  logic [masked_pkg::C_WIDTH-1:0] in_c0,
    input  logic [masked_pkg::C_WIDTH-1:0] in_c1,
    input  masked_pkg::tag_t             in_tag,
    output logic                         in_credit,
    // Result side
    output logic                         out_valid,
    output logic [masked_pkg::Q_WIDTH-1:0] out_r0,
    output logic [masked_pkg::Q_WIDTH-1:0] out_r1,
    output masked_pkg::tag_t             out_tag,
    input  logic                         out_credit
);

    // Stage links
    share_if dec_if ();
    share_if exe_if ();

    req_decode #(
        .LFSR_SEED (LFSR_SEED)
    ) i_req_decode (
        .clk      (clk),
        .rst      (rst),
        .zeroize  (zeroize),
        .in_valid (in_valid),
        .in_c0    (in_c0),
        .in_c1    (in_c1),
        .in_tag   (in_tag),
        .dec      (dec_if.src)
    );

    cond_q_execute i_cond_q_execute (
        .clk     (clk),
        .rst     (rst),
        .zeroize (zeroize),
        .dec     (dec_if.snk),
        .exe     (exe_if.src)
    );

    result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_result_queue (
        .clk        (clk),
        .rst        (rst),
        .zeroize    (zeroize),
        .exe        (exe_if.snk),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_r0     (out_r0),
        .out_r1     (out_r1),
        .out_tag    (out_tag),
        .in_credit  (in_credit)
    );

endmodule

/* cond_q_execute.sv */
`timescale 1ns/1ns
// Masked conditional q subtraction
// Flag = bit 12 or 13 of c0 + c1, masked and ANDed with shared q,
// converted to arithmetic shares and subtracted from c modulo 2^12
// Three cycles, one for the AND and two for the conversion

module cond_q_execute (
    input  logic clk,
    input  logic rst,
    input  logic zeroize,
    share_if.snk dec,
    share_if.src exe
);
    import masked_pkg::*;

    logic [C_WIDTH:0]   c_sum;
    logic               flag;
    logic [1:0]         flag_sh;
    q_shares_t          q_sh;
    logic [Q_WIDTH-1:0] dom_rnd;
    logic [Q_WIDTH-1:0] b2a_rnd;
    logic [1:0]         and_bit [Q_WIDTH];
    q_shares_t          and_bool;
    q_shares_t          and_arith;
    // Delayed request fields
    logic               tag_vld;
    logic               c_vld;
    tag_t               tag_d;
    c_shares_t          c_d;

    // ------------------------------------------------------------
    // Flag detection and share splitting
    // ------------------------------------------------------------
    assign c_sum   = {1'b0, dec.c[0]} + {1'b0, dec.c[1]};
    assign flag    = c_sum[12] | c_sum[13];
    // Refresh the flag into two Boolean shares
    assign flag_sh = {dec.rnd.rnd_1, flag ^ dec.rnd.rnd_1};
    // Split q with the 12-bit mask
    assign q_sh[0] = MLKEM_Q ^ dec.rnd.rnd_12;
    assign q_sh[1] = dec.rnd.rnd_12;
    // Rotated mask for the DOM cross terms
    assign dom_rnd = {dec.rnd.rnd_12[0], dec.rnd.rnd_12[Q_WIDTH-1:1]};

    // Bitwise masked AND of q with the flag
    for (genvar i = 0; i < Q_WIDTH; i++) begin : gen_dom_and
        dom_and i_dom_and (
            .clk     (clk),
            .rst     (rst),
            .zeroize (zeroize),
            .x       (flag_sh),
            .y       ({q_sh[1][i], q_sh[0][i]}),
            .rnd     (dom_rnd[i]),
            .z       (and_bit[i])
        );
    end

    // Repack per-bit products into share words
    always_comb begin
        for (int i = 0; i < Q_WIDTH; i++) begin
            and_bool[0][i] = and_bit[i][0];
            and_bool[1][i] = and_bit[i][1];
        end
    end

    // Conversion mask follows the AND output by one cycle
    always_ff @(posedge clk) begin
        if (zeroize) begin
            b2a_rnd <= '0;
        end else begin
            b2a_rnd <= dec.rnd.rnd_12;
        end
    end

    b2a_conv #(
        .WIDTH (Q_WIDTH)
    ) i_b2a_conv (
        .clk     (clk),
        .rst     (rst),
        .zeroize (zeroize),
        .x_bool  (and_bool),
        .rnd     (b2a_rnd),
        .x_arith (and_arith)
    );

    // ------------------------------------------------------------
    // Tag and c shares ride alongside the masked path
    // ------------------------------------------------------------
    pipe_delay #(
        .STAGES (3),
        .T      (tag_t)
    ) i_tag_delay (
        .clk       (clk),
        .rst       (rst),
        .zeroize   (zeroize),
        .in_valid  (dec.valid),
        .in_data   (dec.tag),
        .out_valid (tag_vld),
        .out_data  (tag_d)
    );

    pipe_delay #(
        .STAGES (3),
        .T      (c_shares_t)
    ) i_c_delay (
        .clk       (clk),
        .rst       (rst),
        .zeroize   (zeroize),
        .in_valid  (dec.valid),
        .in_data   (dec.c),
        .out_valid (c_vld),
        .out_data  (c_d)
    );

    // Share-wise subtraction, result in the low 12 bits
    assign exe.valid = tag_vld & c_vld;
    assign exe.tag   = tag_d;
    assign exe.c[0]  = {{(C_WIDTH-Q_WIDTH){1'b0}}, c_d[0][Q_WIDTH-1:0] - and_arith[0]};
    assign exe.c[1]  = {{(C_WIDTH-Q_WIDTH){1'b0}}, c_d[1][Q_WIDTH-1:0] - and_arith[1]};
    // No randomness past this stage
    assign exe.rnd   = '0;

endmodule

/* dom_and.sv */
`timescale 1ns/1ns
// Domain-oriented masked AND of two 2-share bits
// Cross-domain terms refreshed with one random bit, all terms registered
// Product shares valid one cycle after the operands

module dom_and (
    input  logic       clk,
    input  logic       rst,
    input  logic       zeroize,
    input  logic [1:0] x,
    input  logic [1:0] y,
    input  logic       rnd,
    output logic [1:0] z
);

    // Inner-domain products
    logic inner0_q;
    logic inner1_q;
    // Refreshed cross-domain products
    logic cross01_q;
    logic cross10_q;

    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            inner0_q  <= 1'b0;
            inner1_q  <= 1'b0;
            cross01_q <= 1'b0;
            cross10_q <= 1'b0;
        end else begin
            inner0_q  <= x[0] & y[0];
            inner1_q  <= x[1] & y[1];
            // Same mask on both cross terms, cancels on recombination
            cross01_q <= (x[0] & y[1]) ^ rnd;
            cross10_q <= (x[1] & y[0]) ^ rnd;
        end
    end

    // Compression stays inside each domain
    assign z[0] = inner0_q ^ cross01_q;
    assign z[1] = inner1_q ^ cross10_q;

endmodule

/* filelist.f */
masked_pkg.sv
share_if.sv
dom_and.sv
b2a_conv.sv
pipe_delay.sv
req_decode.sv
cond_q_execute.sv
result_queue.sv
barrett_fix_top.sv
tb_barrett_fix.sv

/* masked_pkg.sv */
// Masked Barrett correction shared definitions
// ML-KEM modulus, share widths, share containers and the masking
// randomness bundle used across the correction pipeline

package masked_pkg;

    // ML-KEM modulus and datapath widths
    localparam int Q_WIDTH   = 12;
    localparam int C_WIDTH   = 14;
    localparam int TAG_WIDTH = 4;

    localparam logic [Q_WIDTH-1:0] MLKEM_Q = 12'd3329;

    // ------------------------------------------------------------
    // Share containers
    // ------------------------------------------------------------

    // Two arithmetic shares of the unreduced coefficient
    typedef logic [1:0][C_WIDTH-1:0] c_shares_t;

    // Two shares of q width, Boolean or arithmetic
    typedef logic [1:0][Q_WIDTH-1:0] q_shares_t;

    // Request tag, returned with the result
    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Fresh randomness drawn once per request
    typedef struct packed {
        logic [Q_WIDTH-1:0] rnd_12;
        logic               rnd_1;
    } rnd_t;

endpackage

/* pipe_delay.sv */
`timescale 1ns/1ns
// Valid-qualified delay line of STAGES registers for any payload type
// Several items may be in flight, zeroize wipes the payload

module pipe_delay #(
    parameter int  STAGES = 3,
    parameter type T      = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic zeroize,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    logic [STAGES-1:0] vld_sr;
    T                  data_sr [STAGES];

    // Valid chain
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // Payload chain, shifts every cycle
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < STAGES; i++) begin
                data_sr[i] <= '0;
            end
        end else begin
            data_sr[0] <= in_data;
            for (int i = 1; i < STAGES; i++) begin
                data_sr[i] <= data_sr[i-1];
            end
        end
    end

    assign out_valid = vld_sr[STAGES-1];
    assign out_data  = data_sr[STAGES-1];

endmodule

/* req_decode.sv */
`timescale 1ns/1ns
// Request decode stage
// Registers credited requests into coefficient shares and attaches
// fresh masking randomness from a 32-bit Galois LFSR

module req_decode #(
    parameter logic [31:0] LFSR_SEED = 32'h1b2c_3d4f
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         zeroize,
    input  logic                         in_valid,
    input  logic [masked_pkg::C_WIDTH-1:0] in_c0,
    input  logic [masked_pkg::C_WIDTH-1:0] in_c1,
    input  masked_pkg::tag_t             in_tag,
    share_if.src                         dec
);
    import masked_pkg::*;

    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [31:0] lfsr;
    logic [31:0] lfsr_next;

    assign lfsr_next = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);

    // ------------------------------------------------------------
    // Control: LFSR state and valid
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            lfsr      <= LFSR_SEED;
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= in_valid;
            // One step per accepted request
            if (in_valid) begin
                lfsr <= lfsr_next;
            end
        end
    end

    // Payload: request shares and randomness
    always_ff @(posedge clk) begin
        if (zeroize) begin
            dec.tag <= '0;
            dec.c   <= '0;
            dec.rnd <= '0;
        end else if (in_valid) begin
            dec.tag        <= in_tag;
            dec.c[0]       <= in_c0;
            dec.c[1]       <= in_c1;
            // Low bits and top bit taken from opposite ends of the state
            dec.rnd.rnd_12 <= lfsr[Q_WIDTH-1:0];
            dec.rnd.rnd_1  <= lfsr[31];
        end
    end

endmodule

/* result_queue.sv */
`timescale 1ns/1ns
// Result FIFO with output-credit counting
// A pop needs a queued result and an output credit, each pop sends
// one result beat and returns one input credit in the same cycle

module result_queue #(
    parameter int QUEUE_DEPTH = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         zeroize,
    share_if.snk                         exe,
    input  logic                         out_credit,
    output logic                         out_valid,
    output logic [masked_pkg::Q_WIDTH-1:0] out_r0,
    output logic [masked_pkg::Q_WIDTH-1:0] out_r1,
    output masked_pkg::tag_t             out_tag,
    output logic                         in_credit
);
    import masked_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);

    typedef struct packed {
        tag_t      tag;
        q_shares_t r;
    } entry_t;

    entry_t           mem [QUEUE_DEPTH];
    entry_t           wr_entry;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credit_cnt;
    logic             push;
    logic             pop;

    // Input credits guarantee room, every beat is written
    assign push = exe.valid;
    assign pop  = (count != '0) && (credit_cnt != '0);

    always_comb begin
        wr_entry.tag  = exe.tag;
        wr_entry.r[0] = exe.c[0][Q_WIDTH-1:0];
        wr_entry.r[1] = exe.c[1][Q_WIDTH-1:0];
    end

    // ------------------------------------------------------------
    // Pointers, occupancy and output credits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRD_W'(OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Returned credit and spent credit in one cycle cancel
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Storage, wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // Output beat and input credit return
    always_ff @(posedge clk) begin
        if (rst || zeroize) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize) begin
            out_tag <= '0;
            out_r0  <= '0;
            out_r1  <= '0;
        end else if (pop) begin
            out_tag <= mem[rd_ptr].tag;
            out_r0  <= mem[rd_ptr].r[0];
            out_r1  <= mem[rd_ptr].r[1];
        end
    end

endmodule

/* share_if.sv */
`timescale 1ns/1ns
// Share link between pipeline stages
// Carries a valid, a tag, two coefficient shares and masking randomness
// No back-pressure, a valid beat is always taken by the sink

interface share_if;
    import masked_pkg::*;

    logic      valid;
    tag_t      tag;
    c_shares_t c;
    rnd_t      rnd;

    // Producing stage
    modport src (
        output valid,
        output tag,
        output c,
        output rnd
    );

    // Consuming stage
    modport snk (
        input valid,
        input tag,
        input c,
        input rnd
    );

endinterface

/* tb_barrett_fix.sv */
`timescale 1ns/1ns
// Testbench for the masked Barrett final correction
// Credited random requests from an xorshift generator, a queue-based
// reference model on the recombined result, credit and zeroize checks

module tb_barrett_fix;
    import masked_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int QUEUE_DEPTH = 8;
    localparam int OUT_CREDITS = 4;
    localparam int TWO_Q       = 2 * int'(MLKEM_Q);
    localparam int DRAIN_LIMIT = 400;

    // Request counts per test
    localparam int N_EDGE      = 24;
    localparam int N_RANDOM    = 400;
    localparam int N_BURST     = 64;
    localparam int N_HOLD      = 8;
    localparam int N_ZERO_PRE  = 10;
    localparam int N_ZERO_POST = 16;
    localparam int TOTAL_REQS  = N_EDGE + N_RANDOM + N_BURST + N_HOLD
                                 + N_ZERO_PRE + N_ZERO_POST;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 200 + 2000;

    logic               clk = 1'b0;
    logic               rst;
    logic               zeroize;
    logic               in_valid;
    logic [C_WIDTH-1:0] in_c0;
    logic [C_WIDTH-1:0] in_c1;
    tag_t               in_tag;
    logic               in_credit;
    logic               out_valid;
    logic [Q_WIDTH-1:0] out_r0;
    logic [Q_WIDTH-1:0] out_r1;
    tag_t               out_tag;
    logic               out_credit = 1'b0;

    // Expected {tag, r} in issue order
    logic [TAG_WIDTH+Q_WIDTH-1:0] expected [$];

    logic [31:0] rng_state = 32'hdd45_0064;
    int          issued = 0;
    int          returned = 0;
    int          owed_credits = 0;
    int          recv_total = 0;
    int          max_outstanding = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;
    logic        hold_credits = 1'b0;
    logic        slow_credits = 1'b0;
    int          slow_phase = 0;
    int          edge_sums [12] = '{4095, 4094, 4000, 4096, 4097, 5000,
                                    6657, 6656, 0, 1, 3328, 3329};

    barrett_fix_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_barrett_fix_top (
        .clk        (clk),
        .rst        (rst),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .in_c0      (in_c0),
        .in_c1      (in_c1),
        .in_tag     (in_tag),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_r0     (out_r0),
        .out_r1     (out_r1),
        .out_tag    (out_tag),
        .out_credit (out_credit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Helpers: random numbers, model, checks
    // ------------------------------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Flag when bit 12 or 13 of the share sum is set, then subtract q mod 2^12
    function automatic logic [Q_WIDTH-1:0] model_result(input int c0, input int c1);
        int sum;
        sum = c0 + c1;
        if ((sum & 32'h3000) != 0) begin
            sum = sum - int'(MLKEM_Q);
        end
        return sum[Q_WIDTH-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d errors", name, errors - test_err_start);
            tests_failed++;
        end
        test_err_start = errors;
    endtask

    // Compare one result beat against the head of the model queue
    task automatic check_result();
        logic [TAG_WIDTH+Q_WIDTH-1:0] entry;
        logic [Q_WIDTH-1:0]           got_r;
        recv_total++;
        if (expected.size() == 0) begin
            report_error($sformatf("result with tag 0x%0h but no request pending", out_tag));
        end else begin
            entry = expected.pop_front();
            got_r = out_r0 + out_r1;
            check_value("out_tag", out_tag, entry[TAG_WIDTH+Q_WIDTH-1:Q_WIDTH]);
            check_value("out_r0+out_r1", got_r, entry[Q_WIDTH-1:0]);
        end
    endtask

    // ------------------------------------------------------------
    // Monitor and output credit return
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (rst || zeroize) begin
            returned     = 0;
            owed_credits = 0;
        end else begin
            if (in_credit !== out_valid) begin
                report_error("input credit pulse not paired with a result beat");
            end
            if (out_valid === 1'b1) begin
                check_result();
                owed_credits++;
            end
            if (out_credit) begin
                owed_credits--;
            end
            if (in_credit === 1'b1) begin
                if (returned >= issued) begin
                    report_error("input credit returned with no request outstanding");
                end else begin
                    returned++;
                end
            end
        end
    end

    // One credit per received result, optionally every third cycle only
    always @(negedge clk) begin
        if (slow_credits) begin
            slow_phase = (slow_phase == 2) ? 0 : slow_phase + 1;
        end else begin
            slow_phase = 0;
        end
        out_credit = !hold_credits && (owed_credits != 0) && (slow_phase == 0);
    end

    // ------------------------------------------------------------
    // Stimulus tasks, all entered and left on a falling edge
    // ------------------------------------------------------------
    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic send_request(input int c0, input int c1, input tag_t tag);
        // Stall while no input credit is held
        while (QUEUE_DEPTH - issued + returned <= 0) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_c0    = c0[C_WIDTH-1:0];
        in_c1    = c1[C_WIDTH-1:0];
        in_tag   = tag;
        expected.push_back({tag, model_result(c0, c1)});
        issued++;
        if (issued - returned > max_outstanding) begin
            max_outstanding = issued - returned;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Shares with a sum in [0, 2q), random tag and gap
    task automatic send_random(input int max_gap);
        logic [31:0] word;
        int          target;
        int          c0;
        int          gap;
        target = int'(next_random() % TWO_Q);
        c0     = int'(next_random() % (target + 1));
        word   = next_random();
        gap    = int'(word[7:0]) % (max_gap + 1);
        send_request(c0, target - c0, word[11:8]);
        if (gap > 0) begin
            idle_cycles(gap);
        end
    endtask

    // Credit mode changes land on a rising edge, away from the return process
    task automatic set_credit_mode(input logic hold, input logic slow);
        @(posedge clk);
        hold_credits = hold;
        slow_credits = slow;
        @(negedge clk);
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        in_valid = 1'b0;
        while ((expected.size() != 0 || owed_credits != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            report_error($sformatf("%0d results never arrived", expected.size()));
            expected.delete();
        end
        idle_cycles(4);
    endtask

    task automatic pulse_zeroize();
        in_valid = 1'b0;
        zeroize  = 1'b1;
        issued   = 0;
        // Requests in flight are dropped by the DUT
        expected.delete();
        @(negedge clk);
        zeroize  = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int mark;
        int c0;
        rst      = 1'b1;
        zeroize  = 1'b0;
        in_valid = 1'b0;
        in_c0    = '0;
        in_c1    = '0;
        in_tag   = '0;

        // Reset state, during reset and while idle afterwards
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("in_credit", in_credit, 0);
        end
        rst = 1'b0;
        repeat (5) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("in_credit", in_credit, 0);
        end
        finish_test("reset_state");

        // Sums around the 4096 flag threshold, two share splits each
        mark = recv_total;
        for (int i = 0; i < N_EDGE / 2; i++) begin
            send_request(0, edge_sums[i], tag_t'(i));
            c0 = int'(next_random() % (edge_sums[i] + 1));
            send_request(c0, edge_sums[i] - c0, tag_t'(i + 3));
        end
        drain_results();
        check_value("edge result count", recv_total - mark, N_EDGE);
        finish_test("flag_threshold");

        mark = recv_total;
        for (int i = 0; i < N_RANDOM; i++) begin
            send_random(3);
        end
        drain_results();
        check_value("random result count", recv_total - mark, N_RANDOM);
        finish_test("random_stream");

        // Slow output credits throttle the queue and then the sender
        mark = recv_total;
        max_outstanding = 0;
        set_credit_mode(1'b0, 1'b1);
        for (int i = 0; i < N_BURST; i++) begin
            send_random(0);
        end
        set_credit_mode(1'b0, 1'b0);
        drain_results();
        check_value("burst result count", recv_total - mark, N_BURST);
        check_value("max outstanding", max_outstanding, QUEUE_DEPTH);
        finish_test("input_credits");

        // No output credits returned, only the initial ones may be spent
        mark = recv_total;
        set_credit_mode(1'b1, 1'b0);
        for (int i = 0; i < N_HOLD; i++) begin
            send_random(0);
        end
        idle_cycles(40);
        check_value("results while held", recv_total - mark, OUT_CREDITS);
        check_value("results waiting", expected.size(), N_HOLD - OUT_CREDITS);
        set_credit_mode(1'b0, 1'b0);
        drain_results();
        check_value("held result count", recv_total - mark, N_HOLD);
        finish_test("output_credits");

        // Zeroize with results queued and in the pipeline
        set_credit_mode(1'b1, 1'b0);
        for (int i = 0; i < N_ZERO_PRE; i++) begin
            send_random(0);
        end
        pulse_zeroize();
        set_credit_mode(1'b0, 1'b0);
        mark = recv_total;
        idle_cycles(20);
        check_value("results after zeroize", recv_total - mark, 0);
        for (int i = 0; i < N_ZERO_POST; i++) begin
            send_random(1);
        end
        drain_results();
        check_value("restart result count", recv_total - mark, N_ZERO_POST);
        finish_test("zeroize");

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the total request count
    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
